/* Makefile */
# Verilator build and run of the cache testbench

VERILATOR ?= verilator
TOP ?= cacheTb
FILELIST ?= tb.f
OBJDIR ?= obj_dir
SEED ?= 96544
VFLAGS ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o V$(TOP)

run: compile
	./$(OBJDIR)/V$(TOP) +verilator+seed+$(SEED)

clean:
	rm -rf $(OBJDIR)

/* tb.f */
verilog/cachePkg.sv
verilog/syncRam.sv
verilog/refillCounter.sv
verilog/cacheCtrl.sv
verilog/lookupStage.sv
verilog/axiRefillMaster.sv
verilog/dcacheTop.sv
test/cacheProtocol_chk.sv
test/cacheTb.sv

/* test/cacheProtocol_chk.sv */
`timescale 1ns/10ps

module cacheProtocolChk (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       arValid_i,
  input  logic [cachePkg::AddrW-1:0] arAddr_i,
  input  logic                       arReady_i,
  input  logic                       respValid_i,
  input  logic                       reqReady_i,
  input  cachePkg::cacheStateT       state_i
);
  import cachePkg::*;

  // number of failed assertions
  int failCount = 0;

  // AR request may not change or drop before the slave takes it
  arHeld: assert property (@(posedge clk) disable iff (!rst_n)
    arValid_i && !arReady_i |=> arValid_i && $stable(arAddr_i))
    else begin
      $error("AR request changed before arReady");
      failCount++;
    end

  arAligned: assert property (@(posedge clk) disable iff (!rst_n)
    arValid_i |-> arAddr_i[2:0] == 3'b000)
    else begin
      $error("AR address not word aligned");
      failCount++;
    end

  // port closed and no response while a line is being fetched
  refillQuiet: assert property (@(posedge clk) disable iff (!rst_n)
    state_i == refill |-> !respValid_i && !reqReady_i)
    else begin
      $error("response or ready during refill");
      failCount++;
    end

  resetQuiet: assert property (@(posedge clk) !rst_n |-> !respValid_i)
    else begin
      $error("response valid during reset");
      failCount++;
    end

endmodule

bind dcacheTop cacheProtocolChk uProtocolChk (
  .clk(clk), .rst_n(rst_n), .arValid_i(arValid_o), .arAddr_i(arAddr_o),
  .arReady_i(arReady_i), .respValid_i(respValid_o), .reqReady_i(reqReady_o),
  .state_i(uCtrl.state)
);

/* test/cacheTb.sv */
`timescale 1ns/10ps

module cacheTb;
  import cachePkg::*;

  localparam int ReadyLimit = 40;
  localparam int RespLimit = 400;

  logic clk;
  logic rst_n;
  logic reqValid;
  logic [AddrW-1:0] reqAddr;
  logic reqReady;
  logic respValid;
  logic [Xlen-1:0] respData;
  logic arValid;
  logic [AddrW-1:0] arAddr;
  logic arReady;
  logic rValid;
  logic [Xlen-1:0] rData;
  logic rReady;

  integer seed;
  int cycleCnt = 0;
  int rBeats = 0;
  int rServed = 0;
  int arServed = 0;
  logic [AddrW-1:0] arLog[$];
  logic [Xlen-1:0] respDataQ[$];
  int respCycQ[$];
  int respArQ[$];
  string nameQ[$];
  logic [AddrW-1:0] reqAddrQ[$];
  int missQ[$];
  int burstQ[$];

  dcacheTop #(.NumSets(64)) dut (
    .clk(clk), .rst_n(rst_n), .reqValid_i(reqValid), .reqAddr_i(reqAddr),
    .reqReady_o(reqReady), .respValid_o(respValid), .respData_o(respData),
    .arValid_o(arValid), .arAddr_o(arAddr), .arReady_i(arReady),
    .rValid_i(rValid), .rData_i(rData), .rReady_o(rReady)
  );

  always #50 clk = ~clk;

  // memory word: address in the upper half, its inverse below
  function automatic logic [Xlen-1:0] memWord(input logic [AddrW-1:0] a);
    return {a, ~a};
  endfunction

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input string what,
                            input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      stopRun($sformatf("error %s %s: expected %0h actual %0h", name, what, exp, act));
    end
  endtask

  always @(posedge clk) begin
    cycleCnt <= cycleCnt + 1;
    if (rst_n && arValid && arReady) begin
      arLog.push_back(arAddr);
    end
    if (rst_n && rValid && rReady) begin
      rBeats++;
    end
  end

  // AXI slave with random stalls on both channels
  always @(negedge clk) begin
    if (rst_n) begin
      if (rValid && rBeats == rServed) begin
        rValid = 1'b0;
      end
      arReady = arValid && (($random(seed) & 3) != 0);
      if (!rValid && arServed < arLog.size() && (($random(seed) & 3) != 0)) begin
        rValid = 1'b1;
        rData = memWord(arLog[arServed]);
        arServed++;
        rServed++;
      end
    end
  end

  always @(negedge clk) begin
    if (rst_n && respValid) begin
      respDataQ.push_back(respData);
      respCycQ.push_back(cycleCnt);
      respArQ.push_back(arLog.size());
    end
  end

  task automatic loadTests();
    int fd;
    int got;
    int miss;
    int burst;
    string line;
    string name;
    logic [AddrW-1:0] addr;
    fd = $fopen("test/cacheTests.txt", "r");
    if (fd == 0) begin
      stopRun("cannot open test/cacheTests.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      got = $fgets(line, fd);
      if (got > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
        got = $sscanf(line, "%s %h %d %d", name, addr, miss, burst);
        if (got != 4) begin
          stopRun({"malformed line in test file: ", line});
        end
        nameQ.push_back(name);
        reqAddrQ.push_back(addr);
        missQ.push_back(miss);
        burstQ.push_back(burst);
      end
    end
    $fclose(fd);
    if (nameQ.size() == 0) begin
      stopRun("test file holds no requests");
    end
  endtask

  task automatic waitReady(input string name);
    int waitCnt;
    waitCnt = 0;
    while (!reqReady) begin
      waitCnt++;
      if (waitCnt > ReadyLimit) begin
        stopRun({"request ", name, " was never accepted"});
      end
      @(negedge clk);
    end
  endtask

  task automatic waitResponse(input string name);
    int waitCnt;
    waitCnt = 0;
    while (respDataQ.size() == 0) begin
      waitCnt++;
      if (waitCnt > RespLimit) begin
        stopRun({"no response arrived for request ", name});
      end
      @(negedge clk);
    end
  endtask

  // one request, then wait for its response
  task automatic runSingle(input int i);
    int acceptCyc;
    int acceptAr;
    logic [AddrW-1:0] base;
    @(negedge clk);
    reqValid = 1'b1;
    reqAddr = reqAddrQ[i];
    waitReady(nameQ[i]);
    acceptCyc = cycleCnt;
    acceptAr = arLog.size();
    @(negedge clk);
    reqValid = 1'b0;
    waitResponse(nameQ[i]);
    checkValue(nameQ[i], "data", memWord({reqAddrQ[i][31:3], 3'b000}), respDataQ.pop_front());
    checkValue(nameQ[i], "AR reads", 64'(4 * missQ[i]), 64'(respArQ.pop_front() - acceptAr));
    if (missQ[i] == 0) begin
      checkValue(nameQ[i], "latency", 64'(2), 64'(respCycQ.pop_front() - acceptCyc));
    end else begin
      void'(respCycQ.pop_front());
      base = {reqAddrQ[i][31:5], 5'b00000};
      for (int b = 0; b < 4; b++) begin
        checkValue(nameQ[i], "AR address", 64'(base + 8 * b), 64'(arLog[acceptAr + b]));
      end
    end
  endtask

  // hits with reqValid held high, one accepted per cycle
  task automatic runBurst(input int first, input int count);
    int startCyc;
    int startAr;
    int idx;
    @(negedge clk);
    reqValid = 1'b1;
    reqAddr = reqAddrQ[first];
    waitReady(nameQ[first]);
    startCyc = cycleCnt;
    startAr = arLog.size();
    for (int k = 1; k < count; k++) begin
      @(negedge clk);
      checkValue(nameQ[first + k], "ready", 64'(1), 64'(reqReady));
      reqAddr = reqAddrQ[first + k];
    end
    @(negedge clk);
    reqValid = 1'b0;
    for (int k = 0; k < count; k++) begin
      idx = first + k;
      waitResponse(nameQ[idx]);
      checkValue(nameQ[idx], "data", memWord({reqAddrQ[idx][31:3], 3'b000}),
                 respDataQ.pop_front());
      checkValue(nameQ[idx], "AR reads", 64'(4 * missQ[idx]),
                 64'(respArQ.pop_front() - startAr));
      checkValue(nameQ[idx], "latency", 64'(2 + k), 64'(respCycQ.pop_front() - startCyc));
    end
  endtask

  initial begin
    int i;
    int n;
    clk = 1'b0;
    rst_n = 1'b0;
    reqValid = 1'b0;
    reqAddr = '0;
    arReady = 1'b0;
    rValid = 1'b0;
    rData = '0;
    seed = 96544;
    loadTests();
    repeat (3) @(negedge clk);
    checkValue("reset", "ready", 64'(0), 64'(reqReady));
    checkValue("reset", "respValid", 64'(0), 64'(respValid));
    checkValue("reset", "arValid", 64'(0), 64'(arValid));
    checkValue("reset", "rReady", 64'(0), 64'(rReady));
    rst_n = 1'b1;
    @(negedge clk);
    checkValue("reset", "ready after release", 64'(1), 64'(reqReady));
    i = 0;
    while (i < nameQ.size()) begin
      if (burstQ[i] != 0) begin
        n = 1;
        while (i + n < nameQ.size() && burstQ[i + n] != 0) begin
          n++;
        end
        runBurst(i, n);
        i += n;
      end else begin
        runSingle(i);
        i++;
      end
    end
    repeat (4) @(negedge clk);
    checkValue("end", "unexpected responses", 64'(0), 64'(respDataQ.size()));
    checkValue("end", "rReady idle", 64'(0), 64'(rReady));
    if (dut.uProtocolChk.failCount != 0) begin
      stopRun("a protocol assertion failed during the run");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

/* test/cacheTests.txt */
# name, byte address in hex, miss (1 = line fetched over AXI), burst (1 = back to back)
# 64 sets of 32-byte lines, so addresses 0x800 apart share a set
coldMiss     00001008 1 0
sameLineHit  00001018 0 0
lineStartHit 00001000 0 0
secondWay    00002010 1 0
secondHit    00002008 0 0
firstStill   00001010 0 0
evictWay0    00003000 1 0
refetch      00001000 1 0
way0Hit      00003018 0 0
evictAgain   00002000 1 0
way1Hit      00001008 0 0
otherSet     000000a8 1 0
topSet       fffff7e8 1 0
burstA       000000a0 0 1
burstB       000000b8 0 1
burstC       fffff7e0 0 1
burstD       00001010 0 1
burstE       00002018 0 1
afterBurst   00003008 1 0
lastHit      00002000 0 0

/* verilog/axiRefillMaster.sv */
`timescale 1ns/10ps

module axiRefillMaster (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      arIssue_i,
  input  logic [cachePkg::AddrW-1:0]                lineAddr_i,
  input  logic [$clog2(cachePkg::BeatsPerLine)-1:0] beatIdx_i,
  input  logic                                      arReady_i,
  input  logic                                      rValid_i,
  input  logic [cachePkg::Xlen-1:0]                 rData_i,
  output logic                                      arValid_o,
  output logic [cachePkg::AddrW-1:0]                arAddr_o,
  output logic                                      rReady_o,
  output logic                                      beatDone_o,
  output cachePkg::lineT                            line_o
);
  import cachePkg::*;

  localparam int ByteW = OffsetW - $clog2(BeatsPerLine);

  assign beatDone_o = rValid_i && rReady_o;

  // AR held until accepted, then wait for its single R beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      arValid_o <= 1'b0;
      rReady_o <= 1'b0;
    end else begin
      if (arIssue_i) begin
        arValid_o <= 1'b1;
      end else if (arReady_i) begin
        arValid_o <= 1'b0;
      end
      if (arValid_o && arReady_i) begin
        rReady_o <= 1'b1;
      end else if (beatDone_o) begin
        rReady_o <= 1'b0;
      end
    end
  end

  // word address of this beat
  always_ff @(posedge clk) begin
    if (arIssue_i) begin
      arAddr_o <= lineAddr_i + (AddrW'(beatIdx_i) << ByteW);
    end
  end

  always_ff @(posedge clk) begin
    if (beatDone_o) begin
      line_o[beatIdx_i] <= rData_i;
    end
  end

endmodule

/* verilog/cacheCtrl.sv */
`timescale 1ns/10ps

module cacheCtrl #(
  parameter int  NumSets = 64,
  localparam int IndexW = $clog2(NumSets)
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reqValid_i,
  input  logic              hit_i,
  input  logic [IndexW-1:0] index_i,
  input  logic              lastBeat_i,
  input  logic              beatDone_i,
  output logic              reqReady_o,
  output logic              accept_o,
  output logic              refillStart_o,
  output logic              arIssue_o,
  output logic [1:0]        tagWe_o,
  output logic              valid0_o,
  output logic              valid1_o,
  output logic              respLoad_o,
  output logic              respValid_o,
  output logic              respondRefill_o
);
  import cachePkg::*;

  cacheStateT state;
  cacheStateT stateNext;
  logic started;
  logic beatPending;
  logic victimWay;
  logic chooseWay;
  logic [NumSets-1:0] valid0Q;
  logic [NumSets-1:0] valid1Q;
  logic [NumSets-1:0] victimQ;

  assign valid0_o = valid0Q[index_i];
  assign valid1_o = valid1Q[index_i];

  // first invalid way, else the set's victim bit
  assign chooseWay = valid0_o && (!valid1_o || victimQ[index_i]);

  // a hit in compare keeps the port open for the next request
  assign reqReady_o = started && (state == idle || (state == compare && hit_i));
  assign accept_o = reqReady_o && reqValid_i;
  assign respLoad_o = (state == compare && hit_i) || state == respond;
  assign respondRefill_o = (state == respond);
  assign refillStart_o = (state == compare) && !hit_i;
  // one AR outstanding at a time
  assign arIssue_o = (state == refill) && !beatPending;
  assign tagWe_o = (state == respond) ? {victimWay, !victimWay} : 2'b00;

  always_comb begin
    stateNext = state;
    case (state)
      idle: begin
        if (accept_o) begin
          stateNext = compare;
        end
      end
      compare: begin
        if (!hit_i) begin
          stateNext = refill;
        end else if (!accept_o) begin
          stateNext = idle;
        end
      end
      refill: begin
        if (beatDone_i && lastBeat_i) begin
          stateNext = respond;
        end
      end
      respond: begin
        stateNext = idle;
      end
      default: begin
        stateNext = idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= idle;
      started <= 1'b0;
      beatPending <= 1'b0;
      victimWay <= 1'b0;
      respValid_o <= 1'b0;
    end else begin
      state <= stateNext;
      started <= 1'b1;
      respValid_o <= respLoad_o;
      if (arIssue_o) begin
        beatPending <= 1'b1;
      end else if (beatDone_i) begin
        beatPending <= 1'b0;
      end
      if (refillStart_o) begin
        victimWay <= chooseWay;
      end
    end
  end

  // line becomes resident when the RAMs are written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid0Q <= '0;
      valid1Q <= '0;
      victimQ <= '0;
    end else if (state == respond) begin
      if (victimWay) begin
        valid1Q[index_i] <= 1'b1;
      end else begin
        valid0Q[index_i] <= 1'b1;
      end
      victimQ[index_i] <= !victimQ[index_i];
    end
  end

endmodule

/* verilog/cachePkg.sv */
package cachePkg;

  // processor address and load word
  localparam int AddrW = 32;
  localparam int Xlen = 64;

  // 32-byte lines of four 64-bit words
  localparam int BeatsPerLine = 4;
  localparam int OffsetW = 5;

  // word 0 sits at the low end, so line[beat] picks one word
  typedef logic [BeatsPerLine-1:0][Xlen-1:0] lineT;

  // controller states
  typedef enum logic [1:0] {
    idle    = 2'd0,
    compare = 2'd1,
    refill  = 2'd2,
    respond = 2'd3
  } cacheStateT;

endpackage

/* verilog/dcacheTop.sv */
`timescale 1ns/10ps

module dcacheTop #(
  parameter int NumSets = 64
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       reqValid_i,
  input  logic [cachePkg::AddrW-1:0] reqAddr_i,
  output logic                       reqReady_o,
  output logic                       respValid_o,
  output logic [cachePkg::Xlen-1:0]  respData_o,
  output logic                       arValid_o,
  output logic [cachePkg::AddrW-1:0] arAddr_o,
  input  logic                       arReady_i,
  input  logic                       rValid_i,
  input  logic [cachePkg::Xlen-1:0]  rData_i,
  output logic                       rReady_o
);
  import cachePkg::*;

  localparam int IndexW = $clog2(NumSets);
  localparam int TagW = AddrW - IndexW - OffsetW;

  typedef logic [TagW-1:0] tagT;

  logic accept;
  logic refillStart;
  logic arIssue;
  logic respLoad;
  logic respondRefill;
  logic hit;
  logic valid0;
  logic valid1;
  logic lastBeat;
  logic beatDone;
  logic [1:0] tagWe;
  logic [IndexW-1:0] index;
  logic [$clog2(BeatsPerLine)-1:0] beatIdx;
  logic [AddrW-1:0] lineAddr;
  tagT tagRd [2];
  lineT lineRd [2];
  lineT refillLine;

  // new request reads the RAMs, a refill writes at the latched set
  wire [IndexW-1:0] ramIdx = accept ? reqAddr_i[OffsetW +: IndexW] : index;
  wire tagT refillTag = lineAddr[AddrW-1 -: TagW];

  cacheCtrl #(.NumSets(NumSets)) uCtrl (
    .clk(clk), .rst_n(rst_n), .reqValid_i(reqValid_i), .hit_i(hit),
    .index_i(index), .lastBeat_i(lastBeat), .beatDone_i(beatDone),
    .reqReady_o(reqReady_o), .accept_o(accept), .refillStart_o(refillStart),
    .arIssue_o(arIssue), .tagWe_o(tagWe), .valid0_o(valid0), .valid1_o(valid1),
    .respLoad_o(respLoad), .respValid_o(respValid_o), .respondRefill_o(respondRefill)
  );

  refillCounter uCounter (
    .clk(clk), .rst_n(rst_n), .clear_i(refillStart), .advance_i(beatDone),
    .beatIdx_o(beatIdx), .lastBeat_o(lastBeat)
  );

  // tag and data RAM per way
  for (genvar w = 0; w < 2; w++) begin : gWay
    syncRam #(.payloadT(tagT), .Depth(NumSets)) uTagRam (
      .clk(clk), .en_i(accept || tagWe[w]), .we_i(tagWe[w]), .addr_i(ramIdx),
      .wData_i(refillTag), .rData_o(tagRd[w])
    );
    syncRam #(.payloadT(lineT), .Depth(NumSets)) uDataRam (
      .clk(clk), .en_i(accept || tagWe[w]), .we_i(tagWe[w]), .addr_i(ramIdx),
      .wData_i(refillLine), .rData_o(lineRd[w])
    );
  end

  lookupStage #(.NumSets(NumSets)) uLookup (
    .clk(clk), .rst_n(rst_n), .accept_i(accept), .reqAddr_i(reqAddr_i),
    .tag0_i(tagRd[0]), .tag1_i(tagRd[1]), .line0_i(lineRd[0]), .line1_i(lineRd[1]),
    .refillLine_i(refillLine), .valid0_i(valid0), .valid1_i(valid1),
    .respondRefill_i(respondRefill), .respLoad_i(respLoad), .hit_o(hit),
    .index_o(index), .lineAddr_o(lineAddr), .respData_o(respData_o)
  );

  axiRefillMaster uAxi (
    .clk(clk), .rst_n(rst_n), .arIssue_i(arIssue), .lineAddr_i(lineAddr),
    .beatIdx_i(beatIdx), .arReady_i(arReady_i), .rValid_i(rValid_i), .rData_i(rData_i),
    .arValid_o(arValid_o), .arAddr_o(arAddr_o), .rReady_o(rReady_o),
    .beatDone_o(beatDone), .line_o(refillLine)
  );

endmodule

/* verilog/lookupStage.sv */
`timescale 1ns/10ps

module lookupStage #(
  parameter int  NumSets = 64,
  localparam int IndexW = $clog2(NumSets),
  localparam int TagW = cachePkg::AddrW - IndexW - cachePkg::OffsetW
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      accept_i,
  input  logic [cachePkg::AddrW-1:0] reqAddr_i,
  input  logic [TagW-1:0]           tag0_i,
  input  logic [TagW-1:0]           tag1_i,
  input  cachePkg::lineT            line0_i,
  input  cachePkg::lineT            line1_i,
  input  cachePkg::lineT            refillLine_i,
  input  logic                      valid0_i,
  input  logic                      valid1_i,
  input  logic                      respondRefill_i,
  input  logic                      respLoad_i,
  output logic                      hit_o,
  output logic [IndexW-1:0]         index_o,
  output logic [cachePkg::AddrW-1:0] lineAddr_o,
  output logic [cachePkg::Xlen-1:0] respData_o
);
  import cachePkg::*;

  localparam int WordSelW = $clog2(BeatsPerLine);
  localparam int ByteW = OffsetW - WordSelW;

  logic [AddrW-1:0] addrQ;
  logic [TagW-1:0] tagQ;
  logic [WordSelW-1:0] wordSel;
  logic match0;
  logic match1;
  lineT srcLine;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addrQ <= '0;
    end else if (accept_i) begin
      addrQ <= reqAddr_i;
    end
  end

  // address fields of the request in compare
  assign tagQ = addrQ[AddrW-1 -: TagW];
  assign index_o = addrQ[OffsetW +: IndexW];
  assign wordSel = addrQ[ByteW +: WordSelW];
  assign lineAddr_o = {addrQ[AddrW-1:OffsetW], {OffsetW{1'b0}}};

  assign match0 = valid0_i && (tag0_i == tagQ);
  assign match1 = valid1_i && (tag1_i == tagQ);
  assign hit_o = match0 || match1;

  // refill line bypasses the RAMs on a miss
  always_comb begin
    if (respondRefill_i) begin
      srcLine = refillLine_i;
    end else if (match1) begin
      srcLine = line1_i;
    end else begin
      srcLine = line0_i;
    end
  end

  always_ff @(posedge clk) begin
    if (respLoad_i) begin
      respData_o <= srcLine[wordSel];
    end
  end

endmodule

/* verilog/refillCounter.sv */
`timescale 1ns/10ps

module refillCounter (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      clear_i,
  input  logic                                      advance_i,
  output logic [$clog2(cachePkg::BeatsPerLine)-1:0] beatIdx_o,
  output logic                                      lastBeat_o
);
  import cachePkg::*;

  // wraps back to beat 0 after the last beat of a line
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatIdx_o <= '0;
    end else if (clear_i) begin
      beatIdx_o <= '0;
    end else if (advance_i) begin
      beatIdx_o <= beatIdx_o + 1'b1;
    end
  end

  assign lastBeat_o = (beatIdx_o == ($clog2(BeatsPerLine))'(BeatsPerLine - 1));

endmodule

/* verilog/syncRam.sv */
`timescale 1ns/10ps

module syncRam #(
  parameter type payloadT = logic [31:0],
  parameter int  Depth = 64
) (
  input  logic                     clk,
  input  logic                     en_i,
  input  logic                     we_i,
  input  logic [$clog2(Depth)-1:0] addr_i,
  input  payloadT                  wData_i,
  output payloadT                  rData_o
);

  payloadT mem [Depth];

  // read-first, output holds while the port is idle
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wData_i;
      end
      rData_o <= mem[addr_i];
    end
  end

endmodule
